// ==== frame_rx_defs.svh ====
// Constants shared by the framed receiver RTL and its testbench; include wherever a value is needed
`ifndef FRAME_RX_DEFS_SVH
`define FRAME_RX_DEFS_SVH

//////////////////////////////////////////////////
// Stream format
//////////////////////////////////////////////////

// Width of one stream word
`define FRX_WIDTH 64

// Marks the start of every frame
// A copy seen inside a frame aborts that frame
`define FRX_PREAMBLE 64'hBA5EBA77B01DFACE

//////////////////////////////////////////////////
// Storage
//////////////////////////////////////////////////

// Base-2 log of the packet FIFO depth
// One frame may hold at most this many data words
`define FRX_DEPTH_LOG2 10

`endif

// ==== frame_rx_pkg.sv ====
// Types shared by the framed receiver blocks; referenced by scoped name, never imported
`include "frame_rx_defs.svh"

package frame_rx_pkg;

   //////////////////////////////////////////////////
   // Stream beat
   //////////////////////////////////////////////////

   // One data word plus its end-of-frame flag
   typedef struct packed {
      logic                  last;
      logic [`FRX_WIDTH-1:0] data;
   } beat_t;

   //////////////////////////////////////////////////
   // Trailer decode
   //////////////////////////////////////////////////

   // Checksum is the XOR of both halves of every data word
   typedef struct packed {
      logic [31:0] checksum;
      logic [31:0] count;
   } trailer_t;

   // An incoming word, either payload or a candidate trailer
   typedef union packed {
      logic [`FRX_WIDTH-1:0] raw;
      trailer_t              trailer;
   } word_u;

endpackage

// ==== frame_skid_reg.sv ====
// Two-entry registered valid/ready stage used for look-ahead and for the FIFO output
`timescale 1ns/100ps

module frame_skid_reg #(
   parameter int WIDTH = 64
) (
   input  logic             clk,
   input  logic             i_rst,
   input  logic             i_clear,
   input  logic [WIDTH-1:0] i_data,
   input  logic             i_valid,
   output logic             o_ready,
   output logic [WIDTH-1:0] o_data,
   output logic             o_valid,
   input  logic             i_ready
);

   // Second entry holds a word only while the output is stalled
   logic [WIDTH-1:0] hold_data;
   logic             hold_valid;
   logic             in_xfer;
   logic             load;

   // Room for a word while the hold entry is free
   assign o_ready = !hold_valid;
   assign in_xfer = i_valid && o_ready;

   // Output entry is free or leaving this cycle
   assign load = !o_valid || i_ready;

   always_ff @(posedge clk) begin
      if (i_rst || i_clear) begin
         o_valid    <= 1'b0;
         hold_valid <= 1'b0;
      end else if (load) begin
         // Hold entry drains first to keep order
         o_valid    <= hold_valid || in_xfer;
         hold_valid <= 1'b0;
      end else if (in_xfer) begin
         hold_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         o_data <= hold_valid ? hold_data : i_data;
      end
      if (!load && in_xfer) begin
         hold_data <= i_data;
      end
   end

endmodule

// ==== frame_strip.sv ====
// Preamble hunt, checksum and count tracking, trailer detection; feeds data beats into the FIFO
`timescale 1ns/100ps
`include "frame_rx_defs.svh"

module frame_strip (
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_clear,
   input  logic [`FRX_WIDTH-1:0] i_data,
   input  logic                  i_valid,
   output logic                  o_ready,
   output frame_rx_pkg::beat_t   o_beat,
   output logic                  o_valid,
   output logic                  o_error,
   input  logic                  i_ready
);

   localparam logic [1:0] IDLE    = 2'd0;
   localparam logic [1:0] PASS    = 2'd1;
   localparam logic [1:0] RECOVER = 2'd2;

   logic [1:0]            state;
   logic [1:0]            next_state;
   logic [31:0]           checksum;
   logic [31:0]           word_cnt;
   frame_rx_pkg::word_u   in_word;
   logic                  in_pass;
   logic                  det_preamble;
   logic                  det_trailer;
   logic                  live;
   logic                  trailer_hit;
   logic                  trailer_acc;
   logic                  data_valid;
   logic                  data_acc;
   logic                  look_space;
   logic                  look_valid;
   logic                  look_ready;
   logic                  look_clear;
   logic [`FRX_WIDTH-1:0] look_data;

   //////////////////////////////////////////////////
   // Word decode
   //////////////////////////////////////////////////

   assign in_word = i_data;
   assign in_pass = (state == PASS);

   assign det_preamble = (in_word.raw == `FRX_PREAMBLE);

   // Only a frame with at least one data word can end
   assign det_trailer = (word_cnt != 32'd0)
                        && (in_word.trailer.checksum == checksum)
                        && (in_word.trailer.count == word_cnt);

   // A data word or a trailer is waiting at the input
   assign live = in_pass && i_valid && !det_preamble;

   // Look-ahead holds exactly one word, so that word is the last one
   assign trailer_hit = det_trailer && look_valid && look_space;
   assign trailer_acc = live && trailer_hit && i_ready;

   assign data_valid = live && !det_trailer;
   assign data_acc   = data_valid && look_space;

   assign o_error = in_pass && i_valid && det_preamble;

   //////////////////////////////////////////////////
   // Running checksum and count
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (i_rst || i_clear || !in_pass) begin
         checksum <= 32'd0;
         word_cnt <= 32'd0;
      end else if (data_acc) begin
         checksum <= checksum ^ in_word.raw[63:32] ^ in_word.raw[31:0];
         word_cnt <= word_cnt + 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Frame FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (i_rst || i_clear) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (i_valid && det_preamble) begin
               next_state = PASS;
            end
         end
         PASS: begin
            if (o_error) begin
               next_state = RECOVER;
            end else if (trailer_acc) begin
               next_state = IDLE;
            end
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   // Preambles always drain; a trailer waits until its last word can go
   always_comb begin
      case (state)
         IDLE:    o_ready = 1'b1;
         PASS: begin
            if (det_preamble) begin
               o_ready = 1'b1;
            end else if (det_trailer) begin
               o_ready = trailer_hit && i_ready;
            end else begin
               o_ready = look_space;
            end
         end
         default: o_ready = 1'b0;
      endcase
   end

   //////////////////////////////////////////////////
   // Look-ahead register
   //////////////////////////////////////////////////

   // Stale words of an aborted frame are flushed in RECOVER
   assign look_clear = i_clear || (state == RECOVER);

   // Head leaves only once the following word is visible
   assign o_valid    = live && look_valid;
   assign look_ready = o_valid && i_ready;

   frame_skid_reg #(
      .WIDTH(`FRX_WIDTH)
   ) i_look_reg (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_clear (look_clear),
      .i_data  (i_data),
      .i_valid (data_valid),
      .o_ready (look_space),
      .o_data  (look_data),
      .o_valid (look_valid),
      .i_ready (look_ready)
   );

   assign o_beat = '{last: trailer_hit, data: look_data};

endmodule

// ==== frame_pkt_fifo.sv ====
// Packet-mode FIFO; releases only complete frames and rewinds the write side when a frame aborts
`timescale 1ns/100ps
`include "frame_rx_defs.svh"

module frame_pkt_fifo #(
   parameter int DEPTH_LOG2 = `FRX_DEPTH_LOG2
) (
   input  logic                clk,
   input  logic                i_rst,
   input  logic                i_clear,
   input  frame_rx_pkg::beat_t i_beat,
   input  logic                i_valid,
   input  logic                i_error,
   output logic                o_ready,
   output frame_rx_pkg::beat_t o_beat,
   output logic                o_valid,
   input  logic                i_ready
);

   localparam int DEPTH  = 1 << DEPTH_LOG2;
   localparam int BEAT_W = $bits(frame_rx_pkg::beat_t);

   frame_rx_pkg::beat_t mem [DEPTH];

   // Pointers carry one extra wrap bit
   logic [DEPTH_LOG2:0] wr_ptr;
   logic [DEPTH_LOG2:0] rd_ptr;
   logic [DEPTH_LOG2:0] frame_ptr;
   logic [DEPTH_LOG2:0] frames_in;
   logic [DEPTH_LOG2:0] frames_out;
   logic                full;
   logic                empty;
   logic                hold;
   logic                write;
   logic                read;
   frame_rx_pkg::beat_t ram_beat;
   logic                ram_valid;
   logic                ram_ready;

   assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2])
                  && (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);
   assign empty = (wr_ptr == rd_ptr);

   assign o_ready = !full;
   assign write   = i_valid && !full && !i_error;

   //////////////////////////////////////////////////
   // Write side
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (write) begin
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_beat;
      end
   end

   // frame_ptr marks the end of the last complete frame
   always_ff @(posedge clk) begin
      if (i_rst || i_clear) begin
         wr_ptr    <= '0;
         frame_ptr <= '0;
         frames_in <= '0;
      end else if (i_error) begin
         wr_ptr <= frame_ptr;
      end else if (write) begin
         wr_ptr <= wr_ptr + 1'b1;
         if (i_beat.last) begin
            frame_ptr <= wr_ptr + 1'b1;
            frames_in <= frames_in + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // Read side
   //////////////////////////////////////////////////

   // Nothing leaves until a whole frame is stored
   assign hold      = (frames_in == frames_out);
   assign ram_beat  = mem[rd_ptr[DEPTH_LOG2-1:0]];
   assign ram_valid = !empty && !hold;
   assign read      = ram_valid && ram_ready;

   always_ff @(posedge clk) begin
      if (i_rst || i_clear) begin
         rd_ptr     <= '0;
         frames_out <= '0;
      end else if (read) begin
         rd_ptr <= rd_ptr + 1'b1;
         if (ram_beat.last) begin
            frames_out <= frames_out + 1'b1;
         end
      end
   end

   // Registered output keeps the RAM read path short
   frame_skid_reg #(
      .WIDTH(BEAT_W)
   ) i_out_reg (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_clear (i_clear),
      .i_data  (ram_beat),
      .i_valid (ram_valid),
      .o_ready (ram_ready),
      .o_data  (o_beat),
      .o_valid (o_valid),
      .i_ready (i_ready)
   );

endmodule

// ==== frame_rx_top.sv ====
// Framed packet receiver top; stripper followed by the packet FIFO on a 64-bit valid/ready stream
`timescale 1ns/100ps
`include "frame_rx_defs.svh"

module frame_rx_top #(
   parameter int DEPTH_LOG2 = `FRX_DEPTH_LOG2
) (
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_clear,
   input  logic [`FRX_WIDTH-1:0] i_data,
   input  logic                  i_valid,
   output logic                  o_ready,
   output frame_rx_pkg::beat_t   o_beat,
   output logic                  o_valid,
   output logic                  o_error,
   input  logic                  i_ready
);

   frame_rx_pkg::beat_t strip_beat;
   logic                strip_valid;
   logic                fifo_ready;

   frame_strip i_frame_strip (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_clear (i_clear),
      .i_data  (i_data),
      .i_valid (i_valid),
      .o_ready (o_ready),
      .o_beat  (strip_beat),
      .o_valid (strip_valid),
      .o_error (o_error),
      .i_ready (fifo_ready)
   );

   // Error pulse also rewinds the FIFO write side
   frame_pkt_fifo #(
      .DEPTH_LOG2(DEPTH_LOG2)
   ) i_frame_pkt_fifo (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_clear (i_clear),
      .i_beat  (strip_beat),
      .i_valid (strip_valid),
      .i_error (o_error),
      .o_ready (fifo_ready),
      .o_beat  (o_beat),
      .o_valid (o_valid),
      .i_ready (i_ready)
   );

endmodule

// ==== frame_rx_checker.sv ====
// Output stream assertions for the framed receiver; bound to frame_rx_top by the testbench
`timescale 1ns/100ps

module frame_rx_checker (
   input logic                clk,
   input logic                i_rst,
   input logic                i_clear,
   input logic                i_out_ready,
   input logic                i_out_valid,
   input frame_rx_pkg::beat_t i_out_beat,
   input logic                i_error
);

   // Count of failed assertions
   int unsigned fail_count = 0;

   // Output side is quiet once reset has been seen
   a_reset_quiet: assert property (@(posedge clk) i_rst |=> !i_out_valid && !i_error)
      else begin
         $error("output valid or error pulse right after reset");
         fail_count++;
      end

   // A stalled beat must not change
   a_hold_stable: assert property (@(posedge clk) disable iff (i_rst || i_clear)
      i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_beat))
      else begin
         $error("output beat changed or dropped while stalled");
         fail_count++;
      end

   a_error_pulse: assert property (@(posedge clk) disable iff (i_rst) i_error |=> !i_error)
      else begin
         $error("error strobe longer than one cycle");
         fail_count++;
      end

endmodule

// ==== tb_frame_rx.sv ====
// Testbench for the framed receiver; runs a table of frames and checks output beats and error pulses
`timescale 1ns/100ps
`include "frame_rx_defs.svh"

module tb_frame_rx;

   typedef struct packed {
      int junk;
      int len;
      bit corrupt;
      bit clear;
      bit stall;
      bit fill;
   } test_t;

   localparam int NUM_TESTS = 10;

   // junk, data words, early preamble, clear, hold output low, must fill FIFO
   localparam test_t TESTS [NUM_TESTS] = '{
      '{0, 1, 1'b0, 1'b0, 1'b0, 1'b0},
      '{3, 4, 1'b0, 1'b0, 1'b0, 1'b0},
      '{1, 5, 1'b1, 1'b0, 1'b0, 1'b0},
      '{0, 3, 1'b0, 1'b0, 1'b0, 1'b0},
      '{2, 7, 1'b0, 1'b0, 1'b0, 1'b0},
      '{0, 4, 1'b0, 1'b0, 1'b1, 1'b0},
      '{1, 16, 1'b0, 1'b0, 1'b1, 1'b1},
      '{0, 6, 1'b0, 1'b1, 1'b0, 1'b0},
      '{2, 2, 1'b0, 1'b0, 1'b0, 1'b0},
      '{0, 12, 1'b0, 1'b0, 1'b0, 1'b0}
   };

   logic                  clk = 1'b0;
   logic                  i_rst;
   logic                  i_clear;
   logic [`FRX_WIDTH-1:0] i_data;
   logic                  i_valid;
   logic                  i_ready = 1'b0;
   logic                  o_ready;
   frame_rx_pkg::beat_t   o_beat;
   logic                  o_valid;
   logic                  o_error;

   frame_rx_pkg::beat_t exp_q [$];
   int beat_errs = 0;
   int beat_checks = 0;
   int other_errs = 0;
   int other_checks = 0;
   int error_pulses = 0;
   int cycles = 0;
   int cycle_limit = 0;
   bit stall_out = 1'b0;
   bit saw_stall = 1'b0;

   frame_rx_top #(
      .DEPTH_LOG2(4)
   ) i_frame_rx_top (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_clear (i_clear),
      .i_data  (i_data),
      .i_valid (i_valid),
      .o_ready (o_ready),
      .o_beat  (o_beat),
      .o_valid (o_valid),
      .o_error (o_error),
      .i_ready (i_ready)
   );

   bind frame_rx_top frame_rx_checker i_frame_rx_checker (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_clear     (i_clear),
      .i_out_ready (i_ready),
      .i_out_valid (o_valid),
      .i_out_beat  (o_beat),
      .i_error     (o_error)
   );

   always #2 clk = ~clk;

   // Random output back-pressure, held low while a fill test builds up
   always @(posedge clk) begin
      #1;
      i_ready = stall_out ? 1'b0 : (($urandom % 4) != 0);
   end

   //////////////////////////////////////////////////
   // Output monitor and run limit
   //////////////////////////////////////////////////

   always @(posedge clk) begin
      if (!i_rst && o_valid && i_ready) begin
         if (exp_q.size() == 0) begin
            $display("Output beat %h arrived at %0t with no frame pending", o_beat, $time);
            beat_errs++;
         end else begin
            compare_beat(o_beat, exp_q.pop_front());
         end
      end
      if (!i_rst && o_error) begin
         error_pulses++;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Run stopped after %0d cycles, the DUT stopped moving data", cycles);
         $display("test failed");
         $finish;
      end
   end

   task automatic compare_beat(input frame_rx_pkg::beat_t got, input frame_rx_pkg::beat_t exp);
      beat_checks++;
      if (got !== exp) begin
         $display("ERROR time=%0t o_beat got=%h exp=%h", $time, got, exp);
         beat_errs++;
      end
   endtask

   task automatic compare_error(input int got, input int exp);
      other_checks++;
      if (got != exp) begin
         $display("ERROR time=%0t o_error pulses got=%0d exp=%0d", $time, got, exp);
         other_errs++;
      end
   endtask

   // Random payload that cannot pass for a preamble or for the pending trailer
   function automatic logic [`FRX_WIDTH-1:0] make_data(input logic [31:0] cs,
                                                       input logic [31:0] cnt);
      frame_rx_pkg::word_u w;
      w.raw = `FRX_PREAMBLE;
      while (w.raw == `FRX_PREAMBLE
             || (cnt != 0 && w.trailer.checksum == cs && w.trailer.count == cnt)) begin
         w.raw = {$urandom, $urandom};
      end
      return w.raw;
   endfunction

   task automatic send_word(input logic [`FRX_WIDTH-1:0] word);
      bit done;
      done = 1'b0;
      if (($urandom % 8) == 0) begin
         @(posedge clk);
         #1;
      end
      i_data  = word;
      i_valid = 1'b1;
      while (!done) begin
         @(posedge clk);
         if (o_ready) begin
            done = 1'b1;
         end else if (stall_out) begin
            saw_stall = 1'b1;
            stall_out = 1'b0;
         end
         #1;
      end
      i_valid = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #1;
      end
   endtask

   //////////////////////////////////////////////////
   // One table entry
   //////////////////////////////////////////////////

   task automatic run_test(input int idx, input test_t t);
      frame_rx_pkg::word_u   tr;
      logic [`FRX_WIDTH-1:0] word;
      int                    sent;
      int                    errs_before;
      int                    pulses_before;
      tr.raw        = '0;
      errs_before   = beat_errs + other_errs;
      pulses_before = error_pulses;
      stall_out     = t.stall;
      saw_stall     = 1'b0;
      for (int k = 0; k < t.junk; k++) begin
         send_word(make_data(32'd0, 32'd0));
      end
      send_word(`FRX_PREAMBLE);
      // Broken and cleared frames stop halfway
      sent = (t.corrupt || t.clear) ? t.len / 2 : t.len;
      for (int k = 0; k < sent; k++) begin
         word = make_data(tr.trailer.checksum, tr.trailer.count);
         tr.trailer.checksum = tr.trailer.checksum ^ word[63:32] ^ word[31:0];
         tr.trailer.count    = tr.trailer.count + 32'd1;
         if (!t.corrupt && !t.clear) begin
            exp_q.push_back('{last: (k == t.len - 1), data: word});
         end
         send_word(word);
      end
      if (t.corrupt) begin
         send_word(`FRX_PREAMBLE);
      end else if (t.clear) begin
         wait_drain();
         i_clear = 1'b1;
         @(posedge clk);
         #1;
         i_clear = 1'b0;
      end else begin
         send_word(tr.raw);
      end
      if (t.fill && !saw_stall) begin
         $display("Input ready never fell while the FIFO was full in test %0d", idx);
         other_errs++;
         stall_out = 1'b0;
      end
      if (!stall_out) begin
         wait_drain();
      end
      compare_error(error_pulses - pulses_before, t.corrupt ? 1 : 0);
      $display("test %0d: %0d junk, %0d data words -> %s", idx, t.junk, t.len,
               (beat_errs + other_errs == errs_before) ? "ok" : "FAILED");
   endtask

   initial begin
      int words;
      int total;
      words   = 0;
      void'($urandom(32'h17d6));
      i_rst   = 1'b1;
      i_clear = 1'b0;
      i_data  = '0;
      i_valid = 1'b0;
      for (int n = 0; n < NUM_TESTS; n++) begin
         words += TESTS[n].junk + TESTS[n].len + 2;
      end
      cycle_limit = 40 * words + 200;
      repeat (16) @(posedge clk);
      #1;
      i_rst = 1'b0;
      for (int n = 0; n < NUM_TESTS; n++) begin
         run_test(n, TESTS[n]);
      end
      stall_out = 1'b0;
      wait_drain();
      // Extra beats after the last frame would be caught here
      repeat (20) @(posedge clk);
      total = beat_errs + other_errs + int'(i_frame_rx_top.i_frame_rx_checker.fail_count);
      $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, beat_checks + other_checks, total);
      if (total == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// ==== frame_rx_top.f ====
+incdir+.
frame_rx_pkg.sv
frame_skid_reg.sv
frame_strip.sv
frame_pkt_fifo.sv
frame_rx_top.sv
frame_rx_checker.sv
tb_frame_rx.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_frame_rx
FILELIST = frame_rx_top.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
